//--- verilog/area_mask_consts.svh
// ----------------------------------------------------------------------
// widths and pipeline depth shared by the area mask RTL and testbench
// ----------------------------------------------------------------------
`ifndef AREA_MASK_CONSTS_SVH
`define AREA_MASK_CONSTS_SVH

// pixel stream
`define AM_DATA_WIDTH 8
`define AM_X_WIDTH 11
`define AM_Y_WIDTH 11

// squared radius, twice the wider coordinate
`define AM_R2_WIDTH (2 * ((`AM_X_WIDTH > `AM_Y_WIDTH) ? `AM_X_WIDTH : `AM_Y_WIDTH))

// enabled cycles from input sample to output
`define AM_LATENCY 8

// configuration write port
`define AM_CFG_ADDR_WIDTH 3
`define AM_CFG_DATA_WIDTH 32

`endif

//--- verilog/area_mask_pkg.sv
// ----------------------------------------------------------------------
// register map and combine mode types for the area mask stage
// ----------------------------------------------------------------------
`default_nettype none

`include "area_mask_consts.svh"

package area_mask_pkg;

    // ADDR_CTRL bits: 0 rect_en, 1 rect_inv, 2 circle_en, 3 circle_inv,
    // 4 thresh_en, 5 thresh_inv, 6 combine, 7 mask_inv, 8 subst_en
    // two-field registers keep the first field in [15:0], the second in [31:16]
    typedef enum logic [`AM_CFG_ADDR_WIDTH-1:0] {
        ADDR_CTRL,
        ADDR_MASK_VALUE,
        ADDR_THRESH,
        ADDR_RECT_X,
        ADDR_RECT_Y,
        ADDR_CIRCLE_XY,
        ADDR_CIRCLE_R2
    } reg_addr_e;

    typedef enum logic {
        COMBINE_AND = 1'b0,
        COMBINE_OR  = 1'b1
    } combine_e;

endpackage

`default_nettype wire

//--- verilog/img_timing_delay.sv
// ----------------------------------------------------------------------
// frame flag delay line, keeps flags aligned with the mask pipeline
// ----------------------------------------------------------------------
`default_nettype none

`include "area_mask_consts.svh"

module img_timing_delay #(
    parameter int LATENCY = `AM_LATENCY
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  cke,
    input  wire  in_line_first,
    input  wire  in_line_last,
    input  wire  in_pixel_first,
    input  wire  in_pixel_last,
    input  wire  in_de,
    input  wire  in_valid,
    output logic out_line_first,
    output logic out_line_last,
    output logic out_pixel_first,
    output logic out_pixel_last,
    output logic out_de,
    output logic out_valid
);

    localparam int FLAG_WIDTH = 6;

    logic [FLAG_WIDTH-1:0] flag_pipe [LATENCY];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LATENCY; i++) begin
                flag_pipe[i] <= '0;
            end
        end else if (cke) begin
            flag_pipe[0] <= {in_line_first, in_line_last, in_pixel_first,
                             in_pixel_last, in_de, in_valid};
            for (int i = 1; i < LATENCY; i++) begin
                flag_pipe[i] <= flag_pipe[i-1];
            end
        end
    end

    assign {out_line_first, out_line_last, out_pixel_first,
            out_pixel_last, out_de, out_valid} = flag_pipe[LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/area_mask_regs.sv
// ----------------------------------------------------------------------
// configuration registers for the area mask, written by a plain strobe
// settings reach the core through shadows refreshed at frame start
// ----------------------------------------------------------------------
`default_nettype none

`include "area_mask_consts.svh"

module area_mask_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cke,
    input  wire                            cfg_we,
    input  wire [`AM_CFG_ADDR_WIDTH-1:0]   cfg_addr,
    input  wire [`AM_CFG_DATA_WIDTH-1:0]   cfg_wdata,
    input  wire                            in_valid,
    input  wire                            in_line_first,
    input  wire                            in_pixel_first,
    output logic                           rect_en,
    output logic                           rect_inv,
    output logic                           circle_en,
    output logic                           circle_inv,
    output logic                           thresh_en,
    output logic                           thresh_inv,
    output area_mask_pkg::combine_e        combine,
    output logic                           mask_inv,
    output logic                           subst_en,
    output logic [`AM_DATA_WIDTH-1:0]      mask_value,
    output logic [`AM_DATA_WIDTH-1:0]      thresh_value,
    output logic [`AM_X_WIDTH-1:0]         rect_left,
    output logic [`AM_X_WIDTH-1:0]         rect_right,
    output logic [`AM_Y_WIDTH-1:0]         rect_top,
    output logic [`AM_Y_WIDTH-1:0]         rect_bottom,
    output logic [`AM_X_WIDTH-1:0]         circle_x,
    output logic [`AM_Y_WIDTH-1:0]         circle_y,
    output logic [`AM_R2_WIDTH-1:0]        circle_radius2
);

    localparam int CTRL_WIDTH = 9;
    localparam int HALF       = `AM_CFG_DATA_WIDTH / 2;
    localparam int CFG_WIDTH  = CTRL_WIDTH + 2 * `AM_DATA_WIDTH + 3 * `AM_X_WIDTH
                              + 3 * `AM_Y_WIDTH + `AM_R2_WIDTH;

    logic [CTRL_WIDTH-1:0]     work_ctrl;
    logic [`AM_DATA_WIDTH-1:0] work_mask_value;
    logic [`AM_DATA_WIDTH-1:0] work_thresh;
    logic [`AM_X_WIDTH-1:0]    work_rect_left;
    logic [`AM_X_WIDTH-1:0]    work_rect_right;
    logic [`AM_Y_WIDTH-1:0]    work_rect_top;
    logic [`AM_Y_WIDTH-1:0]    work_rect_bottom;
    logic [`AM_X_WIDTH-1:0]    work_circle_x;
    logic [`AM_Y_WIDTH-1:0]    work_circle_y;
    logic [`AM_R2_WIDTH-1:0]   work_radius2;
    logic [CFG_WIDTH-1:0]      work_cfg;
    logic [CFG_WIDTH-1:0]      shadow_cfg;
    logic [CFG_WIDTH-1:0]      cur_cfg;
    logic [CTRL_WIDTH-1:0]     cur_ctrl;
    logic                      frame_start;

    // ------------------------------------------------------------------
    // working registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            work_ctrl        <= '0;
            work_mask_value  <= '0;
            work_thresh      <= '0;
            work_rect_left   <= '0;
            work_rect_right  <= '0;
            work_rect_top    <= '0;
            work_rect_bottom <= '0;
            work_circle_x    <= '0;
            work_circle_y    <= '0;
            work_radius2     <= '0;
        end else if (cfg_we) begin
            case (area_mask_pkg::reg_addr_e'(cfg_addr))
                area_mask_pkg::ADDR_CTRL:       work_ctrl <= cfg_wdata[CTRL_WIDTH-1:0];
                area_mask_pkg::ADDR_MASK_VALUE: work_mask_value <= cfg_wdata[`AM_DATA_WIDTH-1:0];
                area_mask_pkg::ADDR_THRESH:     work_thresh <= cfg_wdata[`AM_DATA_WIDTH-1:0];
                area_mask_pkg::ADDR_RECT_X: begin
                    work_rect_left  <= cfg_wdata[`AM_X_WIDTH-1:0];
                    work_rect_right <= cfg_wdata[HALF +: `AM_X_WIDTH];
                end
                area_mask_pkg::ADDR_RECT_Y: begin
                    work_rect_top    <= cfg_wdata[`AM_Y_WIDTH-1:0];
                    work_rect_bottom <= cfg_wdata[HALF +: `AM_Y_WIDTH];
                end
                area_mask_pkg::ADDR_CIRCLE_XY: begin
                    work_circle_x <= cfg_wdata[`AM_X_WIDTH-1:0];
                    work_circle_y <= cfg_wdata[HALF +: `AM_Y_WIDTH];
                end
                area_mask_pkg::ADDR_CIRCLE_R2:  work_radius2 <= cfg_wdata[`AM_R2_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // shadow copy, taken on the enabled cycle of the first pixel
    // ------------------------------------------------------------------
    assign frame_start = cke && in_valid && in_line_first && in_pixel_first;

    assign work_cfg = {work_ctrl, work_mask_value, work_thresh,
                       work_rect_left, work_rect_right, work_rect_top, work_rect_bottom,
                       work_circle_x, work_circle_y, work_radius2};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_cfg <= '0;
        end else if (frame_start) begin
            shadow_cfg <= work_cfg;
        end
    end

    // bypass so the frame-start pixel already sees the new values
    assign cur_cfg = frame_start ? work_cfg : shadow_cfg;

    assign {cur_ctrl, mask_value, thresh_value,
            rect_left, rect_right, rect_top, rect_bottom,
            circle_x, circle_y, circle_radius2} = cur_cfg;

    assign rect_en    = cur_ctrl[0];
    assign rect_inv   = cur_ctrl[1];
    assign circle_en  = cur_ctrl[2];
    assign circle_inv = cur_ctrl[3];
    assign thresh_en  = cur_ctrl[4];
    assign thresh_inv = cur_ctrl[5];
    assign combine    = area_mask_pkg::combine_e'(cur_ctrl[6]);
    assign mask_inv   = cur_ctrl[7];
    assign subst_en   = cur_ctrl[8];

endmodule

`default_nettype wire

//--- verilog/area_mask_core.sv
// ----------------------------------------------------------------------
// mask pipeline: position count, region tests, combine and substitution
// every stage advances only on cke
// ----------------------------------------------------------------------
`default_nettype none

`include "area_mask_consts.svh"

module area_mask_core (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cke,
    input  wire                            rect_en,
    input  wire                            rect_inv,
    input  wire                            circle_en,
    input  wire                            circle_inv,
    input  wire                            thresh_en,
    input  wire                            thresh_inv,
    input  var area_mask_pkg::combine_e    combine,
    input  wire                            mask_inv,
    input  wire                            subst_en,
    input  wire [`AM_DATA_WIDTH-1:0]       mask_value,
    input  wire [`AM_DATA_WIDTH-1:0]       thresh_value,
    input  wire [`AM_X_WIDTH-1:0]          rect_left,
    input  wire [`AM_X_WIDTH-1:0]          rect_right,
    input  wire [`AM_Y_WIDTH-1:0]          rect_top,
    input  wire [`AM_Y_WIDTH-1:0]          rect_bottom,
    input  wire [`AM_X_WIDTH-1:0]          circle_x,
    input  wire [`AM_Y_WIDTH-1:0]          circle_y,
    input  wire [`AM_R2_WIDTH-1:0]         circle_radius2,
    input  wire                            in_valid,
    input  wire                            in_de,
    input  wire                            in_line_first,
    input  wire                            in_pixel_first,
    input  wire [`AM_DATA_WIDTH-1:0]       in_data,
    output logic [`AM_DATA_WIDTH-1:0]      out_data,
    output logic [`AM_DATA_WIDTH-1:0]      out_masked_data,
    output logic                           out_mask
);

    // pixel data rides alongside the whole pipeline
    logic [`AM_DATA_WIDTH-1:0]   data_pipe [`AM_LATENCY];

    logic [`AM_X_WIDTH-1:0]      st0_x;
    logic [`AM_Y_WIDTH-1:0]      st0_y;
    logic [`AM_X_WIDTH-1:0]      st1_dx;
    logic [`AM_Y_WIDTH-1:0]      st1_dy;
    logic [2*`AM_X_WIDTH-1:0]    st2_dx2;
    logic [2*`AM_Y_WIDTH-1:0]    st2_dy2;
    logic [`AM_R2_WIDTH:0]       st3_dist2;
    logic [4:1]                  rect_pipe;
    logic                        st4_circle;
    logic                        st4_thresh;
    logic                        st5_rect;
    logic                        st5_circle;
    logic                        st5_thresh;
    logic                        st6_mask;
    logic [`AM_DATA_WIDTH-1:0]   st7_masked_data;
    logic                        st7_mask;
    logic                        neutral;

    // value that leaves the combine unaffected
    assign neutral = (combine == area_mask_pkg::COMBINE_AND);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `AM_LATENCY; i++) begin
                data_pipe[i] <= '0;
            end
            st0_x           <= '0;
            st0_y           <= '0;
            st1_dx          <= '0;
            st1_dy          <= '0;
            st2_dx2         <= '0;
            st2_dy2         <= '0;
            st3_dist2       <= '0;
            rect_pipe       <= '0;
            st4_circle      <= 1'b0;
            st4_thresh      <= 1'b0;
            st5_rect        <= 1'b0;
            st5_circle      <= 1'b0;
            st5_thresh      <= 1'b0;
            st6_mask        <= 1'b0;
            st7_masked_data <= '0;
            st7_mask        <= 1'b0;
        end else if (cke) begin
            data_pipe[0] <= in_data;
            for (int i = 1; i < `AM_LATENCY; i++) begin
                data_pipe[i] <= data_pipe[i-1];
            end

            // stage 0, position of the incoming pixel
            if (in_valid) begin
                if (in_pixel_first) begin
                    st0_x <= '0;
                    st0_y <= in_line_first ? '0 : st0_y + 1'b1;
                end else begin
                    st0_x <= st0_x + in_de;
                end
            end

            // stage 1, rectangle and distances to the centre
            rect_pipe[1] <= (st0_x >= rect_left) && (st0_x <= rect_right)
                         && (st0_y >= rect_top) && (st0_y <= rect_bottom);
            st1_dx <= (st0_x > circle_x) ? st0_x - circle_x : circle_x - st0_x;
            st1_dy <= (st0_y > circle_y) ? st0_y - circle_y : circle_y - st0_y;

            // stages 2 to 4, squared distance and threshold
            st2_dx2      <= st1_dx * st1_dx;
            st2_dy2      <= st1_dy * st1_dy;
            st3_dist2    <= st2_dx2 + st2_dy2;
            rect_pipe[4:2] <= rect_pipe[3:1];
            st4_circle   <= (st3_dist2 < circle_radius2);
            st4_thresh   <= (data_pipe[3] > thresh_value);

            // stage 5, per-test enable and inversion
            st5_rect   <= rect_en   ? (rect_pipe[4] ^ rect_inv)  : neutral;
            st5_circle <= circle_en ? (st4_circle ^ circle_inv)  : neutral;
            st5_thresh <= thresh_en ? (st4_thresh ^ thresh_inv)  : neutral;

            // stage 6, combine
            if (combine == area_mask_pkg::COMBINE_OR) begin
                st6_mask <= (st5_rect | st5_circle | st5_thresh) ^ mask_inv;
            end else begin
                st6_mask <= (st5_rect & st5_circle & st5_thresh) ^ mask_inv;
            end

            // stage 7, substitution
            st7_masked_data <= (subst_en && st6_mask) ? mask_value : data_pipe[6];
            st7_mask        <= st6_mask;
        end
    end

    assign out_data        = data_pipe[`AM_LATENCY-1];
    assign out_masked_data = st7_masked_data;
    assign out_mask        = st7_mask;

endmodule

`default_nettype wire

//--- verilog/area_mask_top.sv
// ----------------------------------------------------------------------
// area mask stage top, registers beside the mask core and flag delay
// ----------------------------------------------------------------------
`default_nettype none

`include "area_mask_consts.svh"

module area_mask_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cke,
    input  wire                            cfg_we,
    input  wire [`AM_CFG_ADDR_WIDTH-1:0]   cfg_addr,
    input  wire [`AM_CFG_DATA_WIDTH-1:0]   cfg_wdata,
    input  wire                            in_line_first,
    input  wire                            in_line_last,
    input  wire                            in_pixel_first,
    input  wire                            in_pixel_last,
    input  wire                            in_de,
    input  wire [`AM_DATA_WIDTH-1:0]       in_data,
    input  wire                            in_valid,
    output logic                           out_line_first,
    output logic                           out_line_last,
    output logic                           out_pixel_first,
    output logic                           out_pixel_last,
    output logic                           out_de,
    output logic                           out_valid,
    output logic [`AM_DATA_WIDTH-1:0]      out_data,
    output logic [`AM_DATA_WIDTH-1:0]      out_masked_data,
    output logic                           out_mask
);

    // settings from the register block to the core
    logic                       rect_en;
    logic                       rect_inv;
    logic                       circle_en;
    logic                       circle_inv;
    logic                       thresh_en;
    logic                       thresh_inv;
    area_mask_pkg::combine_e    combine;
    logic                       mask_inv;
    logic                       subst_en;
    logic [`AM_DATA_WIDTH-1:0]  mask_value;
    logic [`AM_DATA_WIDTH-1:0]  thresh_value;
    logic [`AM_X_WIDTH-1:0]     rect_left;
    logic [`AM_X_WIDTH-1:0]     rect_right;
    logic [`AM_Y_WIDTH-1:0]     rect_top;
    logic [`AM_Y_WIDTH-1:0]     rect_bottom;
    logic [`AM_X_WIDTH-1:0]     circle_x;
    logic [`AM_Y_WIDTH-1:0]     circle_y;
    logic [`AM_R2_WIDTH-1:0]    circle_radius2;

    area_mask_regs u_regs (.*);

    area_mask_core u_core (.*);

    img_timing_delay #(
        .LATENCY (`AM_LATENCY)
    ) u_delay (.*);

endmodule

`default_nettype wire

//--- verification/tb_area_mask.sv
// ----------------------------------------------------------------------
// testbench for the area mask stage: register writes, 16x12 frames,
// a pixel reference model and concurrent checks on the output stream
// ----------------------------------------------------------------------
`default_nettype none

`include "area_mask_consts.svh"

module tb_area_mask;

    localparam int FRAME_W = 16;
    localparam int FRAME_H = 12;
    localparam int GAP     = 10;
    localparam int TIMEOUT = 6 * (FRAME_W * FRAME_H + GAP) * 3;

    typedef struct packed {
        logic [8:0]                ctrl;
        logic [`AM_DATA_WIDTH-1:0] mask_value;
        logic [`AM_DATA_WIDTH-1:0] thresh;
        logic [`AM_X_WIDTH-1:0]    rl;
        logic [`AM_X_WIDTH-1:0]    rr;
        logic [`AM_Y_WIDTH-1:0]    rt;
        logic [`AM_Y_WIDTH-1:0]    rb;
        logic [`AM_X_WIDTH-1:0]    cx;
        logic [`AM_Y_WIDTH-1:0]    cy;
        logic [`AM_R2_WIDTH-1:0]   r2;
    } cfg_t;

    typedef struct packed {
        logic [15:0]               stamp;
        logic [4:0]                flags;
        logic                      mask;
        logic [`AM_DATA_WIDTH-1:0] masked;
        logic [`AM_DATA_WIDTH-1:0] data;
    } exp_t;

    logic clk, rst_n, cke, cfg_we;
    logic [`AM_CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [`AM_CFG_DATA_WIDTH-1:0] cfg_wdata;
    logic in_line_first, in_line_last, in_pixel_first, in_pixel_last, in_de, in_valid;
    logic [`AM_DATA_WIDTH-1:0] in_data;
    logic out_line_first, out_line_last, out_pixel_first, out_pixel_last, out_de, out_valid;
    logic [`AM_DATA_WIDTH-1:0] out_data, out_masked_data;
    logic out_mask;

    int     stim_x, stim_y, errors, errors_before, checks, cycle_cnt;
    integer seed;
    cfg_t   pend_cfg, act_cfg;
    exp_t   exp_q[$];
    exp_t   head;
    logic   head_valid;
    logic [15:0] en_cycles;

    area_mask_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic cfg_t apply_write(cfg_t c, logic [2:0] a, logic [31:0] w);
        case (area_mask_pkg::reg_addr_e'(a))
            area_mask_pkg::ADDR_CTRL:       c.ctrl = w[8:0];
            area_mask_pkg::ADDR_MASK_VALUE: c.mask_value = w[`AM_DATA_WIDTH-1:0];
            area_mask_pkg::ADDR_THRESH:     c.thresh = w[`AM_DATA_WIDTH-1:0];
            area_mask_pkg::ADDR_RECT_X:     c = '{c.ctrl, c.mask_value, c.thresh, w[10:0],
                                                  w[26:16], c.rt, c.rb, c.cx, c.cy, c.r2};
            area_mask_pkg::ADDR_RECT_Y:     c = '{c.ctrl, c.mask_value, c.thresh, c.rl, c.rr,
                                                  w[10:0], w[26:16], c.cx, c.cy, c.r2};
            area_mask_pkg::ADDR_CIRCLE_XY:  c = '{c.ctrl, c.mask_value, c.thresh, c.rl, c.rr,
                                                  c.rt, c.rb, w[10:0], w[26:16], c.r2};
            area_mask_pkg::ADDR_CIRCLE_R2:  c.r2 = w[`AM_R2_WIDTH-1:0];
            default: ;
        endcase
        return c;
    endfunction

    function automatic exp_t expect_pixel(cfg_t c, int x, int y, logic [7:0] d);
        exp_t e;
        logic neutral, r, ci, t;
        int   dx, dy;
        e = '0;
        neutral = (c.ctrl[6] == area_mask_pkg::COMBINE_AND);
        dx = x - int'(c.cx);
        dy = y - int'(c.cy);
        r = (x >= c.rl) && (x <= c.rr) && (y >= c.rt) && (y <= c.rb);
        ci = (dx * dx + dy * dy) < c.r2;
        t = d > c.thresh;
        r = c.ctrl[0] ? (r ^ c.ctrl[1]) : neutral;
        ci = c.ctrl[2] ? (ci ^ c.ctrl[3]) : neutral;
        t = c.ctrl[4] ? (t ^ c.ctrl[5]) : neutral;
        e.mask = (c.ctrl[6] ? (r | ci | t) : (r & ci & t)) ^ c.ctrl[7];
        e.masked = (c.ctrl[8] && e.mask) ? c.mask_value : d;
        e.data = d;
        return e;
    endfunction

    // frame start takes the pending settings before this edge's write lands
    always @(posedge clk) begin
        exp_t e;
        if (!rst_n) begin
            exp_q.delete();
            pend_cfg = '0;
            act_cfg = '0;
            en_cycles <= '0;
        end else begin
            if (cke && out_valid && exp_q.size() > 0) begin
                exp_q.delete(0);
                checks++;
            end
            if (cke && in_valid) begin
                if (in_line_first && in_pixel_first) begin
                    act_cfg = pend_cfg;
                end
                e = expect_pixel(act_cfg, stim_x, stim_y, in_data);
                e.stamp = en_cycles;
                e.flags = {in_line_first, in_line_last, in_pixel_first, in_pixel_last, in_de};
                exp_q.push_back(e);
            end
            if (cfg_we) begin
                pend_cfg = apply_write(pend_cfg, cfg_addr, cfg_wdata);
            end
            if (cke) begin
                en_cycles <= en_cycles + 16'd1;
            end
        end
        head_valid <= exp_q.size() > 0;
        head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // ------------------------------------------------------------------
    // output checks
    // ------------------------------------------------------------------
    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("FAIL %s got %h expected %h", name, got, want);
        errors++;
    endtask

    a_expected: assert property (@(posedge clk) disable iff (!rst_n)
        cke && out_valid |-> head_valid)
        else begin
            $display("out_valid went high with no pixel pending in the model");
            errors++;
        end
    a_lag: assert property (@(posedge clk) disable iff (!rst_n)
        cke && out_valid && head_valid |-> 16'(en_cycles - head.stamp) == `AM_LATENCY)
        else begin
            $display("pixel left %0d enabled cycles after entering, not %0d",
                     16'($sampled(en_cycles) - $sampled(head.stamp)), `AM_LATENCY);
            errors++;
        end
    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        cke && out_valid && head_valid |->
        {out_line_first, out_line_last, out_pixel_first, out_pixel_last, out_de} == head.flags)
        else report_value("out_flags", $sampled({out_line_first, out_line_last,
                          out_pixel_first, out_pixel_last, out_de}), $sampled(head.flags));
    a_mask: assert property (@(posedge clk) disable iff (!rst_n)
        cke && out_valid && head_valid |-> out_mask == head.mask)
        else report_value("out_mask", $sampled(out_mask), $sampled(head.mask));
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        cke && out_valid && head_valid |-> out_data == head.data)
        else report_value("out_data", $sampled(out_data), $sampled(head.data));
    a_masked: assert property (@(posedge clk) disable iff (!rst_n)
        cke && out_valid && head_valid |-> out_masked_data == head.masked)
        else report_value("out_masked_data", $sampled(out_masked_data),
                          $sampled(head.masked));

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic drive_idle();
        @(posedge clk);
        cke <= 1'b1;
        cfg_we <= 1'b0;
        in_valid <= 1'b0;
        in_de <= 1'b0;
        {in_line_first, in_line_last, in_pixel_first, in_pixel_last} <= 4'b0;
        in_data <= '0;
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        @(posedge clk);
        cfg_we <= 1'b1;
        cfg_addr <= addr;
        cfg_wdata <= data;
        drive_idle();
    endtask

    // optional register write on pixel wr_at, cke stalls when stall is set
    task automatic send_frame(input bit stall, input int wr_at,
                              input logic [2:0] wr_addr, input logic [31:0] wr_data);
        logic [7:0] pix;
        logic       ce;
        logic       first_try;
        int         n;
        n = 0;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                pix = $random(seed);
                first_try = 1'b1;
                do begin
                    @(posedge clk);
                    ce = stall ? (($random(seed) & 3) != 0) : 1'b1;
                    cke <= ce;
                    in_valid <= 1'b1;
                    in_de <= 1'b1;
                    in_line_first <= (y == 0);
                    in_line_last <= (y == FRAME_H - 1);
                    in_pixel_first <= (x == 0);
                    in_pixel_last <= (x == FRAME_W - 1);
                    in_data <= pix;
                    stim_x <= x;
                    stim_y <= y;
                    cfg_we <= (n == wr_at) && first_try;
                    cfg_addr <= wr_addr;
                    cfg_wdata <= wr_data;
                    first_try = 1'b0;
                end while (!ce);
                n++;
            end
        end
        repeat (GAP) drive_idle();
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("%-28s errors %0d", name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, frames did not complete", TIMEOUT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed = 32'hf03;
        errors = 0;
        errors_before = 0;
        checks = 0;
        rst_n = 1'b0;
        cke = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        {in_line_first, in_line_last, in_pixel_first, in_pixel_last} = 4'b0;
        in_de = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        stim_x = 0;
        stim_y = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) drive_idle();

        send_frame(1'b0, -1, '0, '0);
        finish_test("1 reset defaults");

        reg_write(area_mask_pkg::ADDR_MASK_VALUE, 32'ha5);
        reg_write(area_mask_pkg::ADDR_RECT_X, {16'd11, 16'd3});
        reg_write(area_mask_pkg::ADDR_RECT_Y, {16'd8, 16'd2});
        reg_write(area_mask_pkg::ADDR_CTRL, 32'h101);
        send_frame(1'b0, -1, '0, '0);
        reg_write(area_mask_pkg::ADDR_CTRL, 32'h103);
        send_frame(1'b0, -1, '0, '0);
        finish_test("2 rectangle and inverse");

        reg_write(area_mask_pkg::ADDR_CIRCLE_XY, {16'd5, 16'd7});
        reg_write(area_mask_pkg::ADDR_CIRCLE_R2, 32'd20);
        reg_write(area_mask_pkg::ADDR_CTRL, 32'h104);
        send_frame(1'b0, -1, '0, '0);
        finish_test("3 circle");

        reg_write(area_mask_pkg::ADDR_THRESH, 32'h80);
        reg_write(area_mask_pkg::ADDR_CTRL, 32'h1d1);
        send_frame(1'b0, -1, '0, '0);
        finish_test("4 threshold or rectangle");

        // new ctrl lands mid-frame, must wait for the next frame start
        reg_write(area_mask_pkg::ADDR_CTRL, 32'h105);
        send_frame(1'b1, 100, area_mask_pkg::ADDR_CTRL, 32'h1c5);
        send_frame(1'b1, -1, '0, '0);
        finish_test("5 mid-frame write, stalls");

        $display("tests 5, pixels checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/area_mask_pkg.sv
verilog/img_timing_delay.sv
verilog/area_mask_regs.sv
verilog/area_mask_core.sv
verilog/area_mask_top.sv
verification/tb_area_mask.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_area_mask
FILELIST  := project.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
